/* tb.f */
+incdir+bench
hdl/nnPkg.sv
hdl/neuronNode.sv
hdl/denseLayer.sv
hdl/argmaxStage.sv
hdl/nnClassifier.sv
bench/nnClassifierTb.sv

/* bench/nnModel.svh */
`ifndef NN_MODEL_SVH
`define NN_MODEL_SVH

// Widest layer input. The output layer uses only its low HIDDEN words.
typedef logic [nnPkg::FEATURES-1:0][nnPkg::WORD_W-1:0] wordBusT;

// One neuron, straight from the arithmetic rules.
function automatic logic [nnPkg::WORD_W-1:0] refNeuron(
	input wordBusT in,
	input wordBusT weights,
	input logic [nnPkg::WORD_W-1:0] bias,
	input int fanIn
);
	logic [nnPkg::WORD_W-1:0] acc;
	logic [nnPkg::WORD_W-1:0] mask;
	acc = bias;
	for (int i = 0; i < fanIn; i++)
		acc = acc + in[i] * weights[i];  // Wraps at 32 bits.
	if (acc[nnPkg::WORD_W-1])
		return '0;  // Negative sum clamps.
	mask = (32'd1 << nnPkg::ACT_W) - 32'd1;
	return (acc >> nnPkg::FRAC_SHIFT) & mask;
endfunction

// Whole layer, tables picked by isOutput.
function automatic wordBusT refLayer(input wordBusT in, input bit isOutput);
	wordBusT out;
	wordBusT weights;
	logic [nnPkg::WORD_W-1:0] bias;
	int nodes;
	int fanIn;
	out = '0;
	nodes = isOutput ? nnPkg::CLASSES : nnPkg::HIDDEN;
	fanIn = isOutput ? nnPkg::HIDDEN : nnPkg::FEATURES;
	for (int n = 0; n < nodes; n++)
	begin
		weights = '0;
		for (int i = 0; i < fanIn; i++)
		begin
			if (isOutput)
				weights[i] = nnPkg::OUT_WEIGHTS[n][i];
			else
				weights[i] = nnPkg::HIDDEN_WEIGHTS[n][i];
		end
		if (isOutput)
			bias = nnPkg::OUT_BIAS[n];
		else
			bias = nnPkg::HIDDEN_BIAS[n];
		out[n] = refNeuron(in, weights, bias, fanIn);
	end
	return out;
endfunction

// Largest score, unsigned.
function automatic logic [nnPkg::WORD_W-1:0] topScore(input nnPkg::scoreVecT scores);
	logic [nnPkg::WORD_W-1:0] top;
	top = '0;
	for (int c = 0; c < nnPkg::CLASSES; c++)
		if (scores[c] > top)
			top = scores[c];
	return top;
endfunction

function automatic bit hasTie(input nnPkg::scoreVecT scores);
	int hits;
	hits = 0;
	for (int c = 0; c < nnPkg::CLASSES; c++)
		if (scores[c] == topScore(scores))
			hits++;
	return hits > 1;
endfunction

// Features to scores and winning class.
function automatic void refNetwork(
	input nnPkg::featureVecT features,
	output nnPkg::scoreVecT scores,
	output nnPkg::classResultT res
);
	wordBusT hidden;
	wordBusT outBus;
	hidden = refLayer(features, 1'b0);
	outBus = refLayer(hidden, 1'b1);
	scores = outBus[nnPkg::CLASSES-1:0];
	res.score = topScore(scores);
	res.classIdx = '0;
	// Walk down so the lowest matching index is the last one kept.
	for (int c = nnPkg::CLASSES - 1; c >= 0; c--)
		if (scores[c] == res.score)
			res.classIdx = nnPkg::IDX_W'(c);
endfunction

`endif

/* bench/nnClassifierTb.sv */
`timescale 1ns/1ps

module nnClassifierTb;

	`include "nnModel.svh"

	localparam int LATENCY = 2 * nnPkg::NODE_LATENCY + 1;  // Two layers plus argmax.
	localparam int N_ZERO = 4;
	localparam int N_SMALL = 150;
	localparam int N_WIDE = 150;
	localparam int N_TIE = 16;
	localparam int N_RESUME = 10;
	localparam int N_TOTAL = N_ZERO + N_SMALL + N_WIDE + N_TIE + N_RESUME;
	localparam int MAX_CYCLES = 6 * N_TOTAL + 20;  // Generous margin over one vector per cycle.
	localparam logic [31:0] SEED = 32'h1055_4d9d;

	logic clk = 1'b0;
	logic reset;
	nnPkg::featureVecT features;
	nnPkg::scoreVecT scoresOut;
	nnPkg::classResultT result;

	int unsigned cycle = 0;
	int scoreErrors = 0;
	int resultErrors = 0;
	int otherErrors = 0;
	int drainCycles;

	// Expected results in flight, one entry per applied vector.
	string nameQ[$];
	nnPkg::scoreVecT scoreQ[$];
	nnPkg::classResultT resultQ[$];
	int unsigned dueQ[$];

	nnClassifier DUT
	(
		.clk(clk),
		.reset(reset),
		.features(features),
		.scoresOut(scoresOut),
		.result(result)
	);

	always #4 clk = ~clk;

	// ============================================================
	// Cycle count and timeout
	// ============================================================
	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= MAX_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			otherErrors++;
			reportResults();
			$finish;
		end
	end

	task automatic reportResults();
		$display("Errors: scores %0d, result %0d, other %0d",
			scoreErrors, resultErrors, otherErrors);
		if (scoreErrors + resultErrors + otherErrors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
	endtask

	task automatic checkScores(input string name, input nnPkg::scoreVecT expected,
		input nnPkg::scoreVecT actual);
		if (actual !== expected)
		begin
			scoreErrors++;
			$display("Mismatch %s scores: expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic checkResult(input string name, input nnPkg::classResultT expected,
		input nnPkg::classResultT actual);
		if (actual !== expected)
		begin
			resultErrors++;
			$display("Mismatch %s result: expected class %0d score %h, actual class %0d score %h",
				name, expected.classIdx, expected.score, actual.classIdx, actual.score);
		end
	endtask

	task automatic flushExpected();
		nameQ.delete();
		scoreQ.delete();
		resultQ.delete();
		dueQ.delete();
	endtask

	// ============================================================
	// Compare, on the falling edge
	// ============================================================
	always @(negedge clk)
	begin
		if (reset)
			flushExpected();  // Vectors in flight are lost.
		else if (dueQ.size() != 0 && dueQ[0] == cycle)
		begin
			checkScores(nameQ[0], scoreQ[0], scoresOut);
			checkResult(nameQ[0], resultQ[0], result);
			void'(nameQ.pop_front());
			void'(scoreQ.pop_front());
			void'(resultQ.pop_front());
			void'(dueQ.pop_front());
		end
		else
		begin
			// Pipeline still holds only cleared registers.
			checkScores("idle after reset", '0, scoresOut);
			checkResult("idle after reset", '0, result);
		end
	end

	// Call on a rising edge. The counter still shows the previous edge here.
	task automatic driveVector(input string name, input nnPkg::featureVecT vec);
		nnPkg::scoreVecT expScores;
		nnPkg::classResultT expResult;
		features <= vec;
		refNetwork(vec, expScores, expResult);
		nameQ.push_back(name);
		scoreQ.push_back(expScores);
		resultQ.push_back(expResult);
		dueQ.push_back(cycle + 1 + LATENCY);
	endtask

	task automatic applyVector(input string name, input nnPkg::featureVecT vec);
		@(posedge clk);
		driveVector(name, vec);
	endtask

	function automatic nnPkg::featureVecT smallVector();
		nnPkg::featureVecT v;
		for (int i = 0; i < nnPkg::FEATURES; i++)
			v[i] = 32'($urandom_range(2046)) - 32'd1023;  // Magnitude below 2^10.
		return v;
	endfunction

	function automatic nnPkg::featureVecT wideVector();
		nnPkg::featureVecT v;
		for (int i = 0; i < nnPkg::FEATURES; i++)
			v[i] = $urandom;
		return v;
	endfunction

	// Random vector whose top score is shared; zero vector as fallback.
	function automatic nnPkg::featureVecT tieVector();
		nnPkg::featureVecT v;
		nnPkg::scoreVecT s;
		nnPkg::classResultT r;
		for (int t = 0; t < 200; t++)
		begin
			v = wideVector();
			refNetwork(v, s, r);
			if (hasTie(s))
				return v;
		end
		return '0;
	endfunction

	// Reset held for a few cycles, released together with the next vector.
	task automatic pulseReset(input int cycles);
		@(posedge clk);
		reset <= 1'b1;
		features <= smallVector();
		repeat (cycles - 1)
		begin
			@(posedge clk);
			features <= smallVector();
		end
		@(posedge clk);
		reset <= 1'b0;
		driveVector("resume 0", smallVector());
	endtask

	// ============================================================
	// Stimulus
	// ============================================================
	initial
	begin
		void'($urandom(SEED));
		reset = 1'b1;
		features = '0;

		repeat (4) @(posedge clk);
		reset <= 1'b0;
		driveVector("zero 0", '0);
		for (int i = 1; i < N_ZERO; i++)
			applyVector($sformatf("zero %0d", i), '0);

		for (int i = 0; i < N_SMALL; i++)
			applyVector($sformatf("small %0d", i), smallVector());

		for (int i = 0; i < N_WIDE; i++)
			applyVector($sformatf("wide %0d", i), wideVector());

		for (int i = 0; i < N_TIE; i++)
			applyVector($sformatf("tie %0d", i), tieVector());

		pulseReset(3);
		for (int i = 1; i < N_RESUME; i++)
			applyVector($sformatf("resume %0d", i), smallVector());

		drainCycles = 0;
		while (dueQ.size() != 0 && drainCycles < LATENCY + 2)
		begin
			@(posedge clk);
			drainCycles++;
		end
		if (dueQ.size() != 0)
		begin
			$display("Expected results still queued at end of run: %0d left", dueQ.size());
			otherErrors++;
		end
		reportResults();
		$finish;
	end

endmodule

/* hdl/nnClassifier.sv */
`timescale 1ns/1ps

module nnClassifier
(
	input logic clk,
	input logic reset,
	input nnPkg::featureVecT features,
	output nnPkg::scoreVecT scoresOut,
	output nnPkg::classResultT result
);

	nnPkg::hiddenVecT hidden;
	nnPkg::scoreVecT scores;

	// ============================================================
	// Hidden layer, 15 inputs to 4 neurons
	// ============================================================
	denseLayer
	#(
		.FAN_IN(nnPkg::FEATURES),
		.NODES(nnPkg::HIDDEN),
		.WEIGHTS(nnPkg::HIDDEN_WEIGHTS),
		.BIAS(nnPkg::HIDDEN_BIAS)
	)
	hiddenLayer
	(
		.clk(clk),
		.reset(reset),
		.in(features),
		.out(hidden)
	);

	// ============================================================
	// Output layer, 4 inputs to 3 classes
	// ============================================================
	denseLayer
	#(
		.FAN_IN(nnPkg::HIDDEN),
		.NODES(nnPkg::CLASSES),
		.WEIGHTS(nnPkg::OUT_WEIGHTS),
		.BIAS(nnPkg::OUT_BIAS)
	)
	outputLayer
	(
		.clk(clk),
		.reset(reset),
		.in(hidden),
		.out(scores)
	);

	// Winner select, one more cycle.
	argmaxStage argmax
	(
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.scoresOut(scoresOut),
		.result(result)
	);

endmodule

/* hdl/argmaxStage.sv */
`timescale 1ns/1ps

module argmaxStage
(
	input logic clk,
	input logic reset,
	input nnPkg::scoreVecT scores,
	output nnPkg::scoreVecT scoresOut,
	output nnPkg::classResultT result
);

	nnPkg::classResultT best;

	// ============================================================
	// Scan for the top score
	// ============================================================
	// Strict compare keeps the lowest index on a tie.
	always_comb
	begin
		best.classIdx = '0;
		best.score = scores[0];
		for (int c = 1; c < nnPkg::CLASSES; c++)
		begin
			if (scores[c] > best.score)
			begin
				best.classIdx = nnPkg::IDX_W'(c);
				best.score = scores[c];
			end
		end
	end

	// ============================================================
	// Output register
	// ============================================================
	// Scores and winner load together so they stay aligned.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			scoresOut <= '0;
			result <= '0;
		end
		else
		begin
			scoresOut <= scores;
			result <= best;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		result.classIdx < nnPkg::CLASSES);

	// Reported score must be the one at the reported index.
	assert property (@(posedge clk) disable iff (reset)
		result.score == scoresOut[result.classIdx]);

endmodule

/* hdl/denseLayer.sv */
`timescale 1ns/1ps

module denseLayer
#(
	parameter int FAN_IN = nnPkg::FEATURES,
	parameter int NODES = nnPkg::HIDDEN,
	parameter logic [NODES-1:0][FAN_IN-1:0][nnPkg::WORD_W-1:0] WEIGHTS = '0,
	parameter logic [NODES-1:0][nnPkg::WORD_W-1:0] BIAS = '0
)
(
	input logic clk,
	input logic reset,
	input logic [FAN_IN-1:0][nnPkg::WORD_W-1:0] in,
	output logic [NODES-1:0][nnPkg::WORD_W-1:0] out
);

	// ============================================================
	// One neuron per output word
	// ============================================================
	// Every node sees the same input vector; only the tables differ.
	for (genvar n = 0; n < NODES; n++)
	begin : genNode
		neuronNode
		#(
			.FAN_IN(FAN_IN),
			.WEIGHTS(WEIGHTS[n]),  // Row n of the weight table.
			.BIAS(BIAS[n])
		)
		node
		(
			.clk(clk),
			.reset(reset),
			.in(in),
			.act(out[n])
		);
	end

endmodule

/* hdl/neuronNode.sv */
`timescale 1ns/1ps

module neuronNode
#(
	parameter int FAN_IN = nnPkg::FEATURES,
	parameter logic [FAN_IN-1:0][nnPkg::WORD_W-1:0] WEIGHTS = '0,
	parameter logic [nnPkg::WORD_W-1:0] BIAS = '0
)
(
	input logic clk,
	input logic reset,
	input logic [FAN_IN-1:0][nnPkg::WORD_W-1:0] in,
	output logic [nnPkg::WORD_W-1:0] act
);

	logic [FAN_IN-1:0][nnPkg::WORD_W-1:0] inReg;
	logic [nnPkg::WORD_W-1:0] sumNext;
	logic [nnPkg::WORD_W-1:0] sumReg;

	// ReLU, then keep the scaled field of a positive sum.
	function automatic logic [nnPkg::WORD_W-1:0] reluScale(input logic [nnPkg::WORD_W-1:0] sum);
		logic [nnPkg::WORD_W-1:0] scaled;
		scaled = '0;
		if (!sum[nnPkg::WORD_W-1])
		begin
			scaled[nnPkg::ACT_W-1:0] =
				sum[nnPkg::FRAC_SHIFT+nnPkg::ACT_W-1:nnPkg::FRAC_SHIFT];
		end
		return scaled;
	endfunction

	// ============================================================
	// Stage 1, input register
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			inReg <= '0;
		else
			inReg <= in;
	end

	// ============================================================
	// Stage 2, multiply and accumulate
	// ============================================================
	// Products and sums wrap at 32 bits.
	always_comb
	begin
		sumNext = BIAS;
		for (int i = 0; i < FAN_IN; i++)
			sumNext = sumNext + inReg[i] * WEIGHTS[i];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			sumReg <= '0;
		else
			sumReg <= sumNext;
	end

	// ============================================================
	// Stage 3, activation
	// ============================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			act <= '0;
		else
			act <= reluScale(sumReg);
	end

	// Upper bits never carry activation data.
	assert property (@(posedge clk) disable iff (reset)
		act[nnPkg::WORD_W-1:nnPkg::ACT_W] == '0);

endmodule

/* hdl/nnPkg.sv */
package nnPkg;

	// ============================================================
	// Sizes
	// ============================================================
	localparam int WORD_W = 32;
	localparam int FEATURES = 15;
	localparam int HIDDEN = 4;
	localparam int CLASSES = 3;
	localparam int IDX_W = $clog2(CLASSES);  // Class index width.

	// Positive sums keep bits 28 down to 13.
	localparam int FRAC_SHIFT = 13;
	localparam int ACT_W = 16;

	localparam int NODE_LATENCY = 3;  // Input, sum and ReLU registers.

	// ============================================================
	// Hidden layer tables
	// ============================================================
	// Indexed [node][input]. Each row below runs from input 14 down to 0.
	localparam logic signed [HIDDEN-1:0][FEATURES-1:0][WORD_W-1:0] HIDDEN_WEIGHTS = {
		// Node 3.
		32'sd2349, -32'sd716, 32'sd5936, -32'sd4708, 32'sd1242,
		32'sd3570, -32'sd1829, 32'sd365, 32'sd7011, -32'sd2467,
		-32'sd938, 32'sd4125, -32'sd5210, 32'sd1706, 32'sd2883,
		// Node 2.
		32'sd5613, -32'sd3824, 32'sd2665, 32'sd5527, 32'sd2932,
		-32'sd812, -32'sd442, 32'sd3165, 32'sd544, 32'sd644,
		32'sd7433, -32'sd1869, 32'sd1310, 32'sd5105, -32'sd7574,
		// Node 1.
		32'sd2096, 32'sd3845, -32'sd433, 32'sd977, -32'sd6021,
		32'sd5189, 32'sd1458, -32'sd2716, 32'sd3302, -32'sd845,
		32'sd6690, 32'sd2571, -32'sd3987, 32'sd4630, -32'sd1204,
		// Node 0.
		-32'sd5873, 32'sd2218, 32'sd4396, -32'sd1502, 32'sd780,
		-32'sd3310, 32'sd2741, 32'sd5024, -32'sd657, 32'sd1883,
		-32'sd4471, 32'sd912, 32'sd6107, -32'sd2250, 32'sd3418
	};

	// Node 3 first.
	localparam logic signed [HIDDEN-1:0][WORD_W-1:0] HIDDEN_BIAS = {
		-32'sd3011,
		-32'sd2105,
		32'sd1875,
		-32'sd1390
	};

	// ============================================================
	// Output layer tables
	// ============================================================
	// Indexed [class][hidden]. Rows run from hidden 3 down to 0.
	localparam logic signed [CLASSES-1:0][HIDDEN-1:0][WORD_W-1:0] OUT_WEIGHTS = {
		32'sd4870, -32'sd4129, 32'sd1377, 32'sd2048,   // Class 2.
		32'sd2764, 32'sd1932, 32'sd5218, -32'sd3605,   // Class 1.
		-32'sd1147, 32'sd3390, -32'sd2876, 32'sd4512   // Class 0.
	};

	localparam logic signed [CLASSES-1:0][WORD_W-1:0] OUT_BIAS = {
		-32'sd950,
		32'sd1320,
		-32'sd2410
	};

	// ============================================================
	// Data types
	// ============================================================
	typedef logic [FEATURES-1:0][WORD_W-1:0] featureVecT;
	typedef logic [HIDDEN-1:0][WORD_W-1:0] hiddenVecT;
	typedef logic [CLASSES-1:0][WORD_W-1:0] scoreVecT;

	// Winning class and its score.
	typedef struct packed
	{
		logic [IDX_W-1:0] classIdx;
		logic [WORD_W-1:0] score;
	} classResultT;

endpackage
